/* isa_pkg.sv */
package isa_pkg;

    ////////////////////////////////////////////////////////////
    // Field and word types
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm_t;

    localparam int    NUM_REGS = 32;
    localparam word_t PC_STEP  = 32'd4;

    ////////////////////////////////////////////////////////////
    // Primary opcodes
    ////////////////////////////////////////////////////////////

    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;

    ////////////////////////////////////////////////////////////
    // SPECIAL function codes
    ////////////////////////////////////////////////////////////

    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_SLLV = 6'h04;
    localparam funct_t FN_SRLV = 6'h06;
    localparam funct_t FN_SRAV = 6'h07;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

endpackage

/* pipe_pkg.sv */
package pipe_pkg;

    import isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

    ////////////////////////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } ifid_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   alu_op;
        word_t     rs_val;
        reg_addr_t rs_addr;
        word_t     rt_val;
        reg_addr_t rt_addr;
        word_t     imm;
        logic      imm_sel;     // Operand b from immediate
        shamt_t    shamt;
        logic      shift_var;   // Shift amount from rs
        reg_addr_t rd;
    } idex_t;

    // Shared by EX/MEM and MEM/WB
    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        word_t     result;
    } stage_result_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

endpackage

/* fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            instr_valid,
    input  isa_pkg::word_t  instr,
    output pipe_pkg::ifid_t ifid
);

    import isa_pkg::*;
    import pipe_pkg::*;

    word_t pc;

    // Bubbles keep the PC where it is
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc   <= '0;
            ifid <= '0;
        end else begin
            ifid.valid <= instr_valid;
            if (instr_valid) begin
                ifid.pc    <= pc;
                ifid.instr <= instr;
                pc         <= pc + PC_STEP;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_pc_aligned : assert property (
        @(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00
    );

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                    clk,
    input  logic                    arst_n,
    input  isa_pkg::reg_addr_t      rs_addr,
    input  isa_pkg::reg_addr_t      rt_addr,
    output isa_pkg::word_t          rs_data,
    output isa_pkg::word_t          rt_data,
    input  pipe_pkg::stage_result_t wb
);

    import isa_pkg::*;

    word_t regs [NUM_REGS];

    // Zero register, then same-cycle write data, then storage
    function automatic word_t read_port(reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wb.valid && wb.rd == addr) begin
            value = wb.result;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    a_zero_reg : assert property (
        @(posedge clk) disable iff (!arst_n)
        regs[0] == '0
    );

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  pipe_pkg::ifid_t    ifid,
    output isa_pkg::reg_addr_t rs_addr,
    output isa_pkg::reg_addr_t rt_addr,
    input  isa_pkg::word_t     rs_data,
    input  isa_pkg::word_t     rt_data,
    output pipe_pkg::idex_t    idex
);

    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rd_field;
    shamt_t    shamt;
    imm_t      imm;

    alu_op_e   alu_op;
    logic      imm_sel;
    logic      shift_var;
    reg_addr_t dest;
    word_t     imm_ext;

    assign opcode   = ifid.instr[31:26];
    assign rs_addr  = ifid.instr[25:21];
    assign rt_addr  = ifid.instr[20:16];
    assign rd_field = ifid.instr[15:11];
    assign shamt    = ifid.instr[10:6];
    assign funct    = ifid.instr[5:0];
    assign imm      = ifid.instr[15:0];

    ////////////////////////////////////////////////////////////
    // Decoder
    ////////////////////////////////////////////////////////////

    // Unknown encodings keep dest at zero and retire as no-writes
    always_comb begin
        alu_op    = ALU_ADD;
        imm_sel   = 1'b0;
        shift_var = 1'b0;
        dest      = '0;
        if (opcode == OP_SPECIAL) begin
            dest = rd_field;
            case (funct)
                FN_ADDU: alu_op = ALU_ADD;
                FN_SUBU: alu_op = ALU_SUB;
                FN_AND:  alu_op = ALU_AND;
                FN_OR:   alu_op = ALU_OR;
                FN_XOR:  alu_op = ALU_XOR;
                FN_NOR:  alu_op = ALU_NOR;
                FN_SLT:  alu_op = ALU_SLT;
                FN_SLTU: alu_op = ALU_SLTU;
                FN_SLL:  alu_op = ALU_SLL;
                FN_SRL:  alu_op = ALU_SRL;
                FN_SRA:  alu_op = ALU_SRA;
                FN_SLLV: begin
                    alu_op    = ALU_SLL;
                    shift_var = 1'b1;
                end
                FN_SRLV: begin
                    alu_op    = ALU_SRL;
                    shift_var = 1'b1;
                end
                FN_SRAV: begin
                    alu_op    = ALU_SRA;
                    shift_var = 1'b1;
                end
                default: dest = '0;
            endcase
        end else begin
            dest    = rt_addr;
            imm_sel = 1'b1;
            case (opcode)
                OP_ADDIU: alu_op = ALU_ADD;
                OP_SLTI:  alu_op = ALU_SLT;
                OP_SLTIU: alu_op = ALU_SLTU;
                OP_ANDI:  alu_op = ALU_AND;
                OP_ORI:   alu_op = ALU_OR;
                OP_XORI:  alu_op = ALU_XOR;
                OP_LUI:   alu_op = ALU_LUI;
                default: begin
                    dest    = '0;
                    imm_sel = 1'b0;
                end
            endcase
        end
    end

    // Logic ops zero-extend, LUI goes to the upper half
    always_comb begin
        case (opcode)
            OP_ANDI, OP_ORI, OP_XORI: imm_ext = {16'h0000, imm};
            OP_LUI:                   imm_ext = {imm, 16'h0000};
            default:                  imm_ext = {{16{imm[15]}}, imm};
        endcase
    end

    ////////////////////////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idex <= '0;
        end else begin
            idex.valid     <= ifid.valid;
            idex.pc        <= ifid.pc;
            idex.alu_op    <= alu_op;
            idex.rs_val    <= rs_data;
            idex.rs_addr   <= rs_addr;
            idex.rt_val    <= rt_data;
            idex.rt_addr   <= rt_addr;
            idex.imm       <= imm_ext;
            idex.imm_sel   <= imm_sel;
            idex.shamt     <= shamt;
            idex.shift_var <= shift_var;
            idex.rd        <= dest;
        end
    end

endmodule

/* forward_unit.sv */
`timescale 1ns/1ps

module forward_unit (
    input  isa_pkg::reg_addr_t      rs_addr,
    input  isa_pkg::reg_addr_t      rt_addr,
    input  pipe_pkg::stage_result_t exmem,
    input  pipe_pkg::stage_result_t memwb,
    output pipe_pkg::fwd_sel_e      fwd_a,
    output pipe_pkg::fwd_sel_e      fwd_b
);

    import isa_pkg::*;
    import pipe_pkg::*;

    // Younger result in EX/MEM has priority
    function automatic fwd_sel_e pick(reg_addr_t addr);
        fwd_sel_e sel;
        if (exmem.valid && exmem.rd != '0 && exmem.rd == addr) begin
            sel = FWD_EXMEM;
        end else if (memwb.valid && memwb.rd != '0 && memwb.rd == addr) begin
            sel = FWD_MEMWB;
        end else begin
            sel = FWD_RF;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick(rs_addr);
        fwd_b = pick(rt_addr);
    end

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu (
    input  isa_pkg::word_t    a,
    input  isa_pkg::word_t    b,
    input  isa_pkg::shamt_t   shamt,
    input  pipe_pkg::alu_op_e op,
    output isa_pkg::word_t    result
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLT:  result = {31'd0, lt_signed};
            ALU_SLTU: result = {31'd0, lt_unsigned};
            // Shifts act on b, as rt does in the encoding
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = word_t'($signed(b) >>> shamt);
            ALU_LUI:  result = b;
            default:  result = '0;
        endcase
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  pipe_pkg::idex_t         idex,
    output pipe_pkg::stage_result_t exmem,
    output pipe_pkg::stage_result_t memwb
);

    import isa_pkg::*;
    import pipe_pkg::*;

    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    word_t    op_a;
    word_t    rt_fwd;
    word_t    op_b;
    shamt_t   shamt;
    word_t    alu_result;

    function automatic word_t fwd_value(fwd_sel_e sel, word_t rf_val);
        word_t value;
        case (sel)
            FWD_EXMEM: value = exmem.result;
            FWD_MEMWB: value = memwb.result;
            default:   value = rf_val;
        endcase
        return value;
    endfunction

    forward_unit i_forward_unit (
        .rs_addr ( idex.rs_addr ),
        .rt_addr ( idex.rt_addr ),
        .exmem   ( exmem        ),
        .memwb   ( memwb        ),
        .fwd_a   ( fwd_a        ),
        .fwd_b   ( fwd_b        )
    );

    always_comb begin
        op_a   = fwd_value(fwd_a, idex.rs_val);
        rt_fwd = fwd_value(fwd_b, idex.rt_val);
        op_b   = idex.imm_sel ? idex.imm : rt_fwd;
        shamt  = idex.shift_var ? op_a[4:0] : idex.shamt;
    end

    alu i_alu (
        .a      ( op_a       ),
        .b      ( op_b       ),
        .shamt  ( shamt      ),
        .op     ( idex.alu_op ),
        .result ( alu_result )
    );

    ////////////////////////////////////////////////////////////
    // EX/MEM and MEM/WB registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exmem <= '0;
            memwb <= '0;
        end else begin
            exmem.valid  <= idex.valid;
            exmem.pc     <= idex.pc;
            exmem.rd     <= idex.rd;
            exmem.result <= alu_result;
            memwb        <= exmem;
        end
    end

endmodule

/* pipeline.sv */
`timescale 1ns/1ps

module pipeline (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              instr_valid,
    input  isa_pkg::word_t    instr,
    output pipe_pkg::retire_t retire
);

    import isa_pkg::*;
    import pipe_pkg::*;

    ifid_t         ifid;
    idex_t         idex;
    stage_result_t exmem;
    stage_result_t memwb;
    reg_addr_t     rs_addr;
    reg_addr_t     rt_addr;
    word_t         rs_data;
    word_t         rt_data;

    fetch_unit i_fetch_unit (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .instr_valid ( instr_valid ),
        .instr       ( instr       ),
        .ifid        ( ifid        )
    );

    decode_stage i_decode_stage (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .ifid    ( ifid    ),
        .rs_addr ( rs_addr ),
        .rt_addr ( rt_addr ),
        .rs_data ( rs_data ),
        .rt_data ( rt_data ),
        .idex    ( idex    )
    );

    // Write port is the MEM/WB register itself
    reg_file i_reg_file (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .rs_addr ( rs_addr ),
        .rt_addr ( rt_addr ),
        .rs_data ( rs_data ),
        .rt_data ( rt_data ),
        .wb      ( memwb   )
    );

    execute_stage i_execute_stage (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .idex   ( idex   ),
        .exmem  ( exmem  ),
        .memwb  ( memwb  )
    );

    assign retire.valid = memwb.valid;
    assign retire.pc    = memwb.pc;
    assign retire.rd    = memwb.rd;
    assign retire.data  = memwb.result;

endmodule

/* tb_pipeline.sv */
`timescale 1ns/1ps

module tb_pipeline;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int N_INSTR      = 400;
    localparam int DRAIN_LIMIT  = 20;

    localparam funct_t R_FUNCTS [14] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
        FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
    localparam opcode_t I_OPCODES [7] = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI,
        OP_SLTI, OP_SLTIU, OP_LUI};

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        word_t     data;
    } expected_t;

    logic      clk;
    logic      arst_n;
    logic      instr_valid;
    word_t     instr;
    retire_t   retire;

    word_t     rng_state;
    word_t     model_regs [NUM_REGS];
    expected_t exp_q [$];
    int        errors;
    int        checks;

    pipeline i_dut (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .instr_valid ( instr_valid ),
        .instr       ( instr       ),
        .retire      ( retire      )
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Random program source
    ////////////////////////////////////////////////////////////

    function automatic word_t next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Upper bits only, the low bits of an LCG repeat quickly
    function automatic int unsigned pick(int unsigned n);
        word_t rnd;
        rnd = next_rand();
        return rnd[31:16] % n;
    endfunction

    // Registers 0 to 7 only, for dense hazards
    function automatic word_t make_instr();
        word_t       rnd;
        word_t       fields;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        shamt_t      sh;
        funct_t      bad_fn;
        int unsigned k;
        int unsigned ki;
        word_t       word;
        rnd    = next_rand();
        fields = next_rand();
        rs     = {2'b00, rnd[31:29]};
        rt     = {2'b00, rnd[28:26]};
        rd     = {2'b00, rnd[25:23]};
        sh     = rnd[22:18];
        if (pick(20) == 0) begin
            case (pick(4))
                0:       bad_fn = 6'h08;
                1:       bad_fn = 6'h0a;
                2:       bad_fn = 6'h18;
                default: bad_fn = 6'h20;
            endcase
            if (pick(2) == 0) begin
                word = {OP_SPECIAL, rs, rt, rd, sh, bad_fn};
            end else begin
                // Opcodes 0x20 and up are loads, stores and others not kept
                word = {1'b1, rnd[17:13], rs, rt, fields[31:16]};
            end
        end else begin
            k = pick(21);
            if (k < 14) begin
                word = {OP_SPECIAL, rs, rt, rd, sh, R_FUNCTS[k[3:0]]};
            end else begin
                ki   = k - 14;
                word = {I_OPCODES[ki[2:0]], rs, rt, fields[31:16]};
            end
        end
        return word;
    endfunction

    ////////////////////////////////////////////////////////////
    // Sequential reference model
    ////////////////////////////////////////////////////////////

    function automatic void run_model(input word_t word, output reg_addr_t dest,
                                      output word_t value);
        opcode_t   op;
        funct_t    fn;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        shamt_t    sh;
        word_t     a;
        word_t     b;
        word_t     sext;
        word_t     zext;
        op    = word[31:26];
        rs    = word[25:21];
        rt    = word[20:16];
        rd    = word[15:11];
        sh    = word[10:6];
        fn    = word[5:0];
        a     = model_regs[rs];
        b     = model_regs[rt];
        sext  = {{16{word[15]}}, word[15:0]};
        zext  = {16'h0000, word[15:0]};
        value = '0;
        if (op == OP_SPECIAL) begin
            dest = rd;
            case (fn)
                FN_ADDU: value = a + b;
                FN_SUBU: value = a - b;
                FN_AND:  value = a & b;
                FN_OR:   value = a | b;
                FN_XOR:  value = a ^ b;
                FN_NOR:  value = ~(a | b);
                FN_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FN_SLTU: value = (a < b) ? 32'd1 : 32'd0;
                FN_SLL:  value = b << sh;
                FN_SRL:  value = b >> sh;
                FN_SRA:  value = $signed(b) >>> sh;
                FN_SLLV: value = b << a[4:0];
                FN_SRLV: value = b >> a[4:0];
                FN_SRAV: value = $signed(b) >>> a[4:0];
                default: dest = '0;
            endcase
        end else begin
            dest = rt;
            case (op)
                OP_ADDIU: value = a + sext;
                OP_SLTI:  value = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                OP_SLTIU: value = (a < sext) ? 32'd1 : 32'd0;
                OP_ANDI:  value = a & zext;
                OP_ORI:   value = a | zext;
                OP_XORI:  value = a ^ zext;
                OP_LUI:   value = {word[15:0], 16'h0000};
                default:  dest = '0;
            endcase
        end
        if (dest != '0) begin
            model_regs[dest] = value;
        end else begin
            value = '0;
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Retire checker
    ////////////////////////////////////////////////////////////

    // Falling edge, away from the register updates
    always @(negedge clk) begin : compare
        expected_t want;
        if (retire.valid) begin
            if (exp_q.size() == 0) begin
                $display("Retire at %0t with no instruction outstanding, pc %h",
                         $time, retire.pc);
                errors++;
            end else begin
                want = exp_q.pop_front();
                checks++;
                if (retire.pc !== want.pc) begin
                    $display("FAILED at %0t: retire.pc expected %h, got %h",
                             $time, want.pc, retire.pc);
                    errors++;
                end
                if (retire.rd !== want.rd) begin
                    $display("FAILED at %0t: retire.rd expected %0d, got %0d",
                             $time, want.rd, retire.rd);
                    errors++;
                end
                if (want.rd != '0 && retire.data !== want.data) begin
                    $display("FAILED at %0t: retire.data expected %h, got %h",
                             $time, want.data, retire.data);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (RESET_CYCLES + 2 * N_INSTR + 100));
        $display("Watchdog expired before the run finished");
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        word_t     word;
        reg_addr_t dest;
        word_t     value;
        expected_t entry;
        word_t     pc_next;
        int        taken;
        int        bubbles;
        int        leftover;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        rng_state   = 32'h1589c56e;
        errors      = 0;
        checks      = 0;
        pc_next     = '0;
        taken       = 0;
        bubbles     = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        while (taken < N_INSTR) begin
            @(posedge clk);
            if (pick(4) == 0) begin
                // Garbage word, must be ignored
                instr_valid <= 1'b0;
                instr       <= next_rand();
                bubbles++;
            end else begin
                word = make_instr();
                run_model(word, dest, value);
                entry.pc   = pc_next;
                entry.rd   = dest;
                entry.data = value;
                exp_q.push_back(entry);
                pc_next     = pc_next + PC_STEP;
                instr_valid <= 1'b1;
                instr       <= word;
                taken++;
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;

        for (int i = 0; i < DRAIN_LIMIT; i++) begin
            if (exp_q.size() == 0) begin
                break;
            end
            @(posedge clk);
        end
        // Extra cycles to catch any spurious retire
        repeat (8) @(posedge clk);

        leftover = exp_q.size();
        if (leftover != 0) begin
            $display("%0d instructions never retired", leftover);
        end
        $display("Instructions: %0d, bubbles: %0d, checks: %0d, errors: %0d",
                 taken, bubbles, checks, errors + (leftover != 0 ? 1 : 0));
        if (errors == 0 && leftover == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* mini_mips.f */
isa_pkg.sv
pipe_pkg.sv
fetch_unit.sv
reg_file.sv
decode_stage.sv
forward_unit.sv
alu.sv
execute_stage.sv
pipeline.sv
tb_pipeline.sv

/* Makefile */
SRCS := $(shell cat mini_mips.f)

.PHONY: run clean

obj_dir/Vtb_pipeline: mini_mips.f $(SRCS)
	verilator --binary --timing --assert -f mini_mips.f --top-module tb_pipeline

run: obj_dir/Vtb_pipeline
	./obj_dir/Vtb_pipeline | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
